// File: Makefile
TOOL     = verilator --binary
FLAGS    = --assert
TOP      = tb_wb_fabric
FILELIST = filelist.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/wb_crossbar_4x2.sv
// Four-master, two-slave Wishbone crossbar with per-target round-robin and a decode-error target
`timescale 1ns/1ps

module wb_crossbar_4x2 (
	input  logic                   clk,
	input  logic                   rstn,
	input  wb_fabric_pkg::wb_req_t m_req_i [wb_fabric_pkg::N_MASTERS],
	output wb_fabric_pkg::wb_rsp_t m_rsp_o [wb_fabric_pkg::N_MASTERS],
	output wb_fabric_pkg::wb_req_t s_req_o [wb_fabric_pkg::N_SLAVES],
	input  wb_fabric_pkg::wb_rsp_t s_rsp_i [wb_fabric_pkg::N_SLAVES]
);

	typedef enum logic {
		DEC_IDLE,
		DEC_BUSY
	} dec_state_e;

	dec_state_e                              dec_state [wb_fabric_pkg::N_MASTERS];
	wb_fabric_pkg::tgt_t                     m_tgt     [wb_fabric_pkg::N_MASTERS];
	logic [wb_fabric_pkg::N_MASTERS-1:0]     m_owned;

	logic [wb_fabric_pkg::N_MASTERS-1:0]     t_req_vec [wb_fabric_pkg::N_TARGETS];
	logic                                    t_gnt     [wb_fabric_pkg::N_TARGETS];
	wb_fabric_pkg::mid_t                     t_gnt_id  [wb_fabric_pkg::N_TARGETS];
	wb_fabric_pkg::wb_req_t                  t_req     [wb_fabric_pkg::N_TARGETS];
	wb_fabric_pkg::wb_rsp_t                  t_rsp     [wb_fabric_pkg::N_TARGETS];

	logic                                    err_q;

	function automatic logic in_window(
		input logic [wb_fabric_pkg::ADDR_W-1:0] adr,
		input logic [wb_fabric_pkg::ADDR_W-1:0] base,
		input logic [wb_fabric_pkg::ADDR_W-1:0] limit
	);
		return (adr >= base) && (adr <= limit);
	endfunction

	function automatic wb_fabric_pkg::tgt_t decode_tgt(
		input logic [wb_fabric_pkg::ADDR_W-1:0] adr
	);
		if (in_window(adr, wb_fabric_pkg::SLV0_BASE, wb_fabric_pkg::SLV0_LIMIT)) begin
			return wb_fabric_pkg::tgt_t'(0);
		end
		if (in_window(adr, wb_fabric_pkg::SLV1_BASE, wb_fabric_pkg::SLV1_LIMIT)) begin
			return wb_fabric_pkg::tgt_t'(1);
		end
		return wb_fabric_pkg::tgt_t'(wb_fabric_pkg::ERR_TARGET);
	endfunction

	// Per-master decode: latch the target on a new strobe, release on ack or err
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < wb_fabric_pkg::N_MASTERS; m++) begin
				dec_state[m] <= DEC_IDLE;
				m_tgt[m]     <= '0;
			end
		end else begin
			for (int m = 0; m < wb_fabric_pkg::N_MASTERS; m++) begin
				case (dec_state[m])
					DEC_IDLE: begin
						if (m_req_i[m].cyc && m_req_i[m].stb) begin
							dec_state[m] <= DEC_BUSY;
							m_tgt[m]     <= decode_tgt(m_req_i[m].adr);
						end
					end
					DEC_BUSY: begin
						if (m_rsp_o[m].ack || m_rsp_o[m].err) begin
							dec_state[m] <= DEC_IDLE;
							m_tgt[m]     <= '0;
						end
					end
					default: dec_state[m] <= DEC_IDLE;
				endcase
			end
		end
	end

	// Request lines into each target's arbiter
	always_comb begin
		for (int t = 0; t < wb_fabric_pkg::N_TARGETS; t++) begin
			for (int m = 0; m < wb_fabric_pkg::N_MASTERS; m++) begin
				t_req_vec[t][m] = (dec_state[m] == DEC_BUSY) &&
					(m_tgt[m] == wb_fabric_pkg::tgt_t'(t));
			end
		end
	end

	for (genvar t = 0; t < wb_fabric_pkg::N_TARGETS; t++) begin : g_tgt
		wb_rr_arbiter #(
			.N_REQ (wb_fabric_pkg::N_MASTERS)
		) u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (t_req_vec[t]),
			.gnt_o    (t_gnt[t]),
			.gnt_id_o (t_gnt_id[t])
		);

		// Only a grant whose holder is still decoding here reaches the target
		assign t_req[t] = (t_gnt[t] && t_req_vec[t][t_gnt_id[t]]) ?
			m_req_i[t_gnt_id[t]] : '0;
	end

	for (genvar s = 0; s < wb_fabric_pkg::N_SLAVES; s++) begin : g_slv
		assign s_req_o[s] = t_req[s];
		assign t_rsp[s]   = s_rsp_i[s];
	end

	// Decode-error target answers every granted strobe with one err pulse
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= t_req[wb_fabric_pkg::ERR_TARGET].cyc &&
				t_req[wb_fabric_pkg::ERR_TARGET].stb && !err_q;
		end
	end

	assign t_rsp[wb_fabric_pkg::ERR_TARGET] = '{dat_r: '0, ack: 1'b0, err: err_q};

	// Response goes back only to the master that holds its target
	for (genvar m = 0; m < wb_fabric_pkg::N_MASTERS; m++) begin : g_rsp
		assign m_owned[m] = (dec_state[m] == DEC_BUSY) && t_gnt[m_tgt[m]] &&
			(t_gnt_id[m_tgt[m]] == wb_fabric_pkg::mid_t'(m));
		assign m_rsp_o[m] = m_owned[m] ? t_rsp[m_tgt[m]] : '0;
	end

endmodule

// File: design/wb_fabric_pkg.sv
// Bus widths, address map and request/response structs shared by every fabric module
package wb_fabric_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int SEL_W     = DATA_W / 8;
	localparam int N_MASTERS = 4;
	localparam int N_SLAVES  = 2;
	localparam int MID_W     = 2;

	// Memory slaves plus the internal decode-error target
	localparam int N_TARGETS  = N_SLAVES + 1;
	localparam int TGT_W      = 2;
	localparam int ERR_TARGET = N_SLAVES;

	// Inclusive byte-address windows
	localparam logic [ADDR_W-1:0] SLV0_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] SLV0_LIMIT = 32'h0000_03FF;
	localparam logic [ADDR_W-1:0] SLV1_BASE  = 32'h0000_1000;
	localparam logic [ADDR_W-1:0] SLV1_LIMIT = 32'h0000_13FF;

	// Words per register file, indexed by address bits 9:2
	localparam int MEM_WORDS = 256;

	typedef logic [MID_W-1:0] mid_t;
	typedef logic [TGT_W-1:0] tgt_t;

	// Master to slave
	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat_w;
		logic [SEL_W-1:0]  sel;
		logic              we;
		logic              cyc;
		logic              stb;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic [DATA_W-1:0] dat_r;
		logic              ack;
		logic              err;
	} wb_rsp_t;

endpackage

// File: design/wb_fabric_top.sv
// Fabric top level: four master ports into the crossbar, two register-file slaves behind it
`timescale 1ns/1ps

module wb_fabric_top (
	input  logic                   clk,
	input  logic                   rstn,
	input  wb_fabric_pkg::wb_req_t m_req_i [wb_fabric_pkg::N_MASTERS],
	output wb_fabric_pkg::wb_rsp_t m_rsp_o [wb_fabric_pkg::N_MASTERS]
);

	wb_fabric_pkg::wb_req_t s_req [wb_fabric_pkg::N_SLAVES];
	wb_fabric_pkg::wb_rsp_t s_rsp [wb_fabric_pkg::N_SLAVES];

	wb_crossbar_4x2 u_xbar (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	// Slave 0 at 0x0000, slave 1 at 0x1000
	wb_reg_slave u_slv0 (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[0]),
		.rsp_o (s_rsp[0])
	);

	wb_reg_slave u_slv1 (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[1]),
		.rsp_o (s_rsp[1])
	);

endmodule

// File: design/wb_reg_slave.sv
// Wishbone register-file slave with byte-lane writes and a registered one-cycle ack
`timescale 1ns/1ps

module wb_reg_slave (
	input  logic                   clk,
	input  logic                   rstn,
	input  wb_fabric_pkg::wb_req_t req_i,
	output wb_fabric_pkg::wb_rsp_t rsp_o
);

	logic [wb_fabric_pkg::DATA_W-1:0]              mem [wb_fabric_pkg::MEM_WORDS];
	logic [$clog2(wb_fabric_pkg::MEM_WORDS)-1:0]   idx;
	logic [wb_fabric_pkg::DATA_W-1:0]              rd_q;
	logic                                          ack_q;
	logic                                          access;

	// Word index from the byte address
	assign idx    = req_i.adr[$clog2(wb_fabric_pkg::MEM_WORDS)+1:2];
	// No new access while the previous ack is still out
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_q <= mem[idx];   // old word, before this cycle's write
			if (req_i.we) begin
				for (int b = 0; b < wb_fabric_pkg::SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
					end
				end
			end
		end
	end

	assign rsp_o = '{dat_r: rd_q, ack: ack_q, err: 1'b0};

endmodule

// File: design/wb_rr_arbiter.sv
// Round-robin arbiter for one crossbar target; grant is held until the winner drops its request
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = 4
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	logic [N_REQ-1:0]         gnt_q;
	logic [N_REQ-1:0]         last_q;
	logic [$clog2(N_REQ)-1:0] id_q;
	logic [N_REQ-1:0]         above_last;
	logic [N_REQ-1:0]         pool;
	logic [N_REQ-1:0]         pick_oh;
	logic [$clog2(N_REQ)-1:0] pick_id;

	always_comb begin
		// Ones strictly above the last winner, empty after reset
		above_last = ~((last_q - 1'b1) | last_q);
		// Prefer requesters above the last winner, else wrap to the lowest one
		pool = (|(req_i & above_last)) ? (req_i & above_last) : req_i;
		pick_id = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (pool[i]) begin
				pick_id = ($clog2(N_REQ))'(i);
			end
		end
		pick_oh = '0;
		pick_oh[pick_id] = |pool;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q  <= '0;
			last_q <= '0;
			id_q   <= '0;
		end else if (gnt_q == '0) begin
			if (|req_i) begin
				gnt_q  <= pick_oh;
				last_q <= pick_oh;
				id_q   <= pick_id;
			end
		end else if ((gnt_q & req_i) == '0) begin
			// Holder went away, free the target for one cycle
			gnt_q <= '0;
		end
	end

	assign gnt_o    = |gnt_q;
	assign gnt_id_o = id_q;

endmodule

// File: filelist.f
design/wb_fabric_pkg.sv
design/wb_rr_arbiter.sv
design/wb_crossbar_4x2.sv
design/wb_reg_slave.sv
design/wb_fabric_top.sv
tb/wb_crossbar_sva.sv
tb/tb_wb_fabric.sv

// File: tb/tb_wb_fabric.sv
// Directed tests of the Wishbone fabric through all four master ports against a reference memory
`timescale 1ns/1ps

module tb_wb_fabric;

	// About three times the expected length of all tests together
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int NM = wb_fabric_pkg::N_MASTERS;

	logic                   clk;
	logic                   rstn;
	wb_fabric_pkg::wb_req_t m_req [NM];
	wb_fabric_pkg::wb_rsp_t m_rsp [NM];

	// Reference copy of both slaves with a flag for each fully written word
	logic [31:0] ref_mem   [2][wb_fabric_pkg::MEM_WORDS];
	logic        ref_valid [2][wb_fabric_pkg::MEM_WORDS];
	logic [31:0] lfsr;
	int          cycle;
	int          errors;
	int          checks;
	// Round-robin bookkeeping per master
	logic        rr_check;
	logic        busy       [NM];
	int          wait_start [NM];
	int          last_ack   [NM];

	wb_fabric_top u_wb_fabric_top (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp)
	);

	bind wb_crossbar_4x2 wb_crossbar_sva u_sva (
		.clk     (clk),
		.rstn    (rstn),
		.m_rsp   (m_rsp_o),
		.m_owned (m_owned),
		.m_tgt   (m_tgt)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a bus transfer never finished", cycle);
			$display("Testbench failed");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per returned bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] slave_addr(input int s, input logic [7:0] idx);
		return ((s == 0) ? wb_fabric_pkg::SLV0_BASE : wb_fabric_pkg::SLV1_BASE) +
			{22'd0, idx, 2'b00};
	endfunction

	// A master waiting since this master's previous ack must have been served first
	task automatic check_fairness(input int m);
		for (int k = 0; k < NM; k++) begin
			checks++;
			if (k != m && last_ack[m] >= 0 && busy[k] && wait_start[k] < last_ack[m]) begin
				errors++;
				$display("FAIL %0t: master %0d acked twice while master %0d waited", $time, m, k);
			end
		end
	endtask

	// One classic cycle that holds the strobe until ack or err and then drops it
	task automatic bus_xfer(input int m, input logic we, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel,
			output logic [31:0] rdat, output logic ack, output logic err);
		@(negedge clk);
		m_req[m] = '{adr: adr, dat_w: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
		busy[m]       = 1'b1;
		wait_start[m] = cycle;
		do begin
			@(negedge clk);
		end while (!(m_rsp[m].ack || m_rsp[m].err));
		rdat     = m_rsp[m].dat_r;
		ack      = m_rsp[m].ack;
		err      = m_rsp[m].err;
		m_req[m] = '0;
		busy[m]  = 1'b0;
		if (rr_check) begin
			check_fairness(m);
		end
		last_ack[m] = cycle;
	endtask

	task automatic bus_write(input int m, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int          s;
		bus_xfer(m, 1'b1, adr, dat, sel, rdat, ack, err);
		checks++;
		if (!ack || err) begin
			errors++;
			$display("FAIL %0t: master %0d write to %h not acknowledged", $time, m, adr);
		end
		s = (adr >= wb_fabric_pkg::SLV1_BASE) ? 1 : 0;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				ref_mem[s][adr[9:2]][8*b +: 8] = dat[8*b +: 8];
			end
		end
		if (sel == 4'hF) begin
			ref_valid[s][adr[9:2]] = 1'b1;
		end
	endtask

	task automatic bus_read(input int m, input logic [31:0] adr);
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int          s;
		bus_xfer(m, 1'b0, adr, 32'h0, 4'hF, rdat, ack, err);
		s = (adr >= wb_fabric_pkg::SLV1_BASE) ? 1 : 0;
		checks++;
		if (!ack || err) begin
			errors++;
			$display("FAIL %0t: master %0d read of %h not acknowledged", $time, m, adr);
		end else if (rdat !== ref_mem[s][adr[9:2]]) begin
			errors++;
			$display("FAIL %0t: master %0d read %h from %h, expected %h", $time, m, rdat, adr,
				ref_mem[s][adr[9:2]]);
		end
	endtask

	task automatic idle_quiet();
		repeat (20) begin
			@(negedge clk);
			for (int m = 0; m < NM; m++) begin
				checks++;
				if (m_rsp[m].ack || m_rsp[m].err) begin
					errors++;
					$display("FAIL %0t: master %0d sees a response while idle", $time, m);
				end
			end
		end
	endtask

	// Full word first so partial lanes land on a known value
	task automatic byte_lane_writes();
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 4; i++) begin
				bus_write(0, slave_addr(s, 8'(i * 84 + 3)), rand_bits(32), 4'hF);
				bus_write(0, slave_addr(s, 8'(i * 84 + 3)), rand_bits(32), 4'b0011 << i);
			end
		end
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 4; i++) begin
				bus_read(0, slave_addr(s, 8'(i * 84 + 3)));
			end
		end
	endtask

	task automatic decode_errors();
		logic [31:0] bad;
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		for (int m = 0; m < NM; m++) begin
			// 0x400, 0x4400, 0x8400, 0xC400 all fall outside both windows
			bad = 32'h0000_0400 + 32'(m) * 32'h0000_4000;
			bus_xfer(m, 1'(m % 2), bad, rand_bits(32), 4'hF, rdat, ack, err);
			checks++;
			if (!err || ack || rdat !== 32'h0) begin
				errors++;
				$display("FAIL %0t: master %0d at %h got ack %b err %b data %h", $time, m, bad,
					ack, err, rdat);
			end
			bus_write(m, slave_addr(m % 2, 8'(200 + m)), rand_bits(32), 4'hF);
			bus_read(m, slave_addr(m % 2, 8'(200 + m)));
		end
	endtask

	task automatic contend(input int m);
		logic [31:0] adr;
		for (int i = 0; i < 6; i++) begin
			adr = slave_addr(0, 8'(16 + 4 * i + m));
			bus_write(m, adr, rand_bits(32), 4'hF);
			bus_read(m, adr);
		end
	endtask

	task automatic round_robin_contention();
		for (int k = 0; k < NM; k++) begin
			last_ack[k] = -1;
		end
		rr_check = 1'b1;
		fork
			contend(0);
			contend(1);
			contend(2);
			contend(3);
		join
		rr_check = 1'b0;
	endtask

	task automatic parallel_slaves();
		logic [31:0] a0;
		logic [31:0] a1;
		a0 = slave_addr(0, 8'h40);
		a1 = slave_addr(1, 8'h40);
		bus_write(0, a0, 32'h0, 4'hF);
		bus_write(0, a1, 32'h0, 4'hF);
		fork
			bus_write(1, a0, 32'hA5A5_0001, 4'hF);
			bus_write(2, a1, 32'h5A5A_0002, 4'hF);
		join
		fork
			bus_read(1, a0);
			bus_read(2, a1);
		join
		// same word index in the other slave must be untouched
		bus_read(0, a1);
		bus_read(0, a0);
	endtask

	task automatic random_traffic();
		int          m;
		int          s;
		logic [7:0]  idx;
		logic [31:0] adr;
		for (int n = 0; n < 200; n++) begin
			m   = int'(rand_bits(2));
			s   = int'(rand_bits(1));
			idx = 8'(rand_bits(8));
			adr = slave_addr(s, idx);
			if (rand_bits(1) == 32'd1 && ref_valid[s][idx]) begin
				bus_read(m, adr);
			end else if (ref_valid[s][idx]) begin
				bus_write(m, adr, rand_bits(32), 4'(rand_bits(4)));
			end else begin
				bus_write(m, adr, rand_bits(32), 4'hF);
			end
		end
	endtask

	initial begin
		clk      = 1'b0;
		rstn     = 1'b0;
		lfsr     = 32'h5d25;
		cycle    = 0;
		errors   = 0;
		checks   = 0;
		rr_check = 1'b0;
		for (int m = 0; m < NM; m++) begin
			m_req[m]      = '0;
			busy[m]       = 1'b0;
			wait_start[m] = 0;
			last_ack[m]   = -1;
		end
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < wb_fabric_pkg::MEM_WORDS; i++) begin
				ref_mem[s][i]   = '0;
				ref_valid[s][i] = 1'b0;
			end
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		idle_quiet();
		byte_lane_writes();
		decode_errors();
		round_robin_contention();
		parallel_slaves();
		random_traffic();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb/wb_crossbar_sva.sv
// Crossbar protocol assertions that bind attaches to every crossbar instance
`timescale 1ns/1ps

module wb_crossbar_sva (
	input logic                                clk,
	input logic                                rstn,
	input wb_fabric_pkg::wb_rsp_t              m_rsp   [wb_fabric_pkg::N_MASTERS],
	input logic [wb_fabric_pkg::N_MASTERS-1:0] m_owned,
	input wb_fabric_pkg::tgt_t                 m_tgt   [wb_fabric_pkg::N_MASTERS]
);

	for (genvar m = 0; m < wb_fabric_pkg::N_MASTERS; m++) begin : g_master
		// A transfer ends with either ack or err
		a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
			!(m_rsp[m].ack && m_rsp[m].err))
			else $error("master %0d saw ack and err together", m);

		// Termination is a single-cycle pulse
		a_rsp_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
			(m_rsp[m].ack || m_rsp[m].err) |=> !(m_rsp[m].ack || m_rsp[m].err))
			else $error("master %0d response lasted more than one cycle", m);

		for (genvar k = 0; k < wb_fabric_pkg::N_MASTERS; k++) begin : g_other
			if (k != m) begin : g_pair
				// A held target goes to no other master before ack or err
				a_single_owner: assert property (@(posedge clk) disable iff (!rstn)
					(m_owned[m] && !(m_rsp[m].ack || m_rsp[m].err)) |=>
					!(m_owned[k] && (m_tgt[k] == m_tgt[m])))
					else $error("master %0d took target %0d from master %0d", k, m_tgt[m], m);
			end
		end
	end

endmodule
